//--- design/ring_pkg.sv
// led ring types and constants
package ring_pkg;

  // ring geometry
  localparam int RING_LEDS = 12;

  // one bit per led, bit 0 is position 0
  typedef logic [RING_LEDS-1:0] led_mask_t;

  // binary index of the lit position, 0 to 11
  typedef logic [3:0] led_index_t;

  // brightness request from the level pins
  typedef logic [1:0] level_t;

  // pwm on-time per 256-cycle frame
  typedef logic [7:0] duty_t;

  // inversion flag on top of the index
  typedef logic [4:0] status_t;

  // duty per brightness level
  localparam duty_t DUTY_L0 = 8'd1;
  localparam duty_t DUTY_L1 = 8'd2;
  localparam duty_t DUTY_L2 = 8'd8;
  localparam duty_t DUTY_L3 = 8'd32;

endpackage

//--- design/input_pkg.sv
// input conditioning constants and types
package input_pkg;

  // depth of the pin synchronizers
  localparam int SYNC_STAGES = 2;

  // cycles a new button level must hold before it counts
  localparam int DEBOUNCE_CYCLES = 16;

  // wide enough to hold DEBOUNCE_CYCLES
  typedef logic [4:0] db_count_t;

  // debouncer states
  typedef enum logic [1:0] {
    DB_RELEASED,
    DB_CONFIRM_PRESS,
    DB_PRESSED,
    DB_CONFIRM_RELEASE
  } db_state_t;

endpackage

//--- design/quad_decoder.sv
// rotary encoder step decoder
`timescale 1ns/1ns

module quad_decoder (
  input  logic clk,
  input  logic rst_i,
  input  logic enc_a_i,
  input  logic enc_b_i,
  output logic step_up_o,
  output logic step_dn_o
);
  import input_pkg::*;

  logic [SYNC_STAGES-1:0] a_sync;
  logic [SYNC_STAGES-1:0] b_sync;
  logic                   a_s;
  logic                   b_s;
  logic                   a_d;    // previous synchronized a
  logic                   a_rise;

  assign a_s    = a_sync[SYNC_STAGES-1];
  assign b_s    = b_sync[SYNC_STAGES-1];
  assign a_rise = a_s & ~a_d;

  // pin synchronizers and edge history
  always_ff @(posedge clk) begin
    if (rst_i) begin
      a_sync <= '0;
      b_sync <= '0;
      a_d    <= 1'b0;
    end else begin
      a_sync <= {a_sync[SYNC_STAGES-2:0], enc_a_i};
      b_sync <= {b_sync[SYNC_STAGES-2:0], enc_b_i};
      a_d    <= a_s;
    end
  end

  // b decides direction at the rising edge of a
  always_ff @(posedge clk) begin
    if (rst_i) begin
      step_up_o <= 1'b0;
      step_dn_o <= 1'b0;
    end else begin
      step_up_o <= a_rise & ~b_s;
      step_dn_o <= a_rise & b_s;
    end
  end

endmodule

//--- design/button_debounce.sv
// push button debouncer
`timescale 1ns/1ns

module button_debounce (
  input  logic clk,
  input  logic rst_i,
  input  logic button_i,
  output logic press_o
);
  import input_pkg::*;

  logic [SYNC_STAGES-1:0] btn_sync;
  logic                   btn_s;
  db_state_t              state;
  db_count_t              count;    // consecutive cycles at the new level
  logic                   count_done;

  assign btn_s      = btn_sync[SYNC_STAGES-1];
  assign count_done = (count == db_count_t'(DEBOUNCE_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      btn_sync <= '0;
    end else begin
      btn_sync <= {btn_sync[SYNC_STAGES-2:0], button_i};
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state   <= DB_RELEASED;
      count   <= '0;
      press_o <= 1'b0;
    end else begin
      press_o <= 1'b0;
      case (state)
        DB_RELEASED: begin
          if (btn_s) begin
            state <= DB_CONFIRM_PRESS;
            count <= db_count_t'(1);  // first high sample
          end
        end
        DB_CONFIRM_PRESS: begin
          if (!btn_s) begin
            state <= DB_RELEASED;  // bounce, back to idle
          end else if (count_done) begin
            state   <= DB_PRESSED;
            press_o <= 1'b1;
          end else begin
            count <= count + 1'b1;
          end
        end
        DB_PRESSED: begin
          if (!btn_s) begin
            state <= DB_CONFIRM_RELEASE;
            count <= db_count_t'(1);
          end
        end
        DB_CONFIRM_RELEASE: begin
          if (btn_s) begin
            state <= DB_PRESSED;
          end else if (count_done) begin
            state <= DB_RELEASED;
          end else begin
            count <= count + 1'b1;
          end
        end
        default: state <= DB_RELEASED;
      endcase
    end
  end

endmodule

//--- design/ring_controller.sv
// led ring position controller
`timescale 1ns/1ns

module ring_controller (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                step_up_i,
  input  logic                step_dn_i,
  input  logic                press_i,
  input  ring_pkg::level_t    level_i,
  output ring_pkg::led_mask_t mask_o,
  output ring_pkg::duty_t     duty_o,
  output ring_pkg::status_t   status_o
);
  import ring_pkg::*;

  led_mask_t  pos;        // one-hot lit position
  logic       inverted;
  led_index_t pos_index;

  assign mask_o = pos ^ {RING_LEDS{inverted}};

  // one-hot to binary
  always_comb begin
    pos_index = '0;
    for (int i = 0; i < RING_LEDS; i++) begin
      if (pos[i]) begin
        pos_index = led_index_t'(i);
      end
    end
  end

  // rotate with wrap both ways
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pos <= led_mask_t'(1);
    end else if (step_up_i) begin
      pos <= {pos[RING_LEDS-2:0], pos[RING_LEDS-1]};
    end else if (step_dn_i) begin
      pos <= {pos[0], pos[RING_LEDS-1:1]};  // 0 wraps to 11
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      inverted <= 1'b0;
    end else if (press_i) begin
      inverted <= ~inverted;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      status_o <= '0;
    end else begin
      status_o <= {inverted, pos_index};
    end
  end

  // brightness level to one-hot duty
  always_ff @(posedge clk) begin
    if (rst_i) begin
      duty_o <= DUTY_L0;
    end else begin
      case (level_i)
        2'd0:    duty_o <= DUTY_L0;
        2'd1:    duty_o <= DUTY_L1;
        2'd2:    duty_o <= DUTY_L2;
        default: duty_o <= DUTY_L3;
      endcase
    end
  end

endmodule

//--- design/pwm_dimmer.sv
// pwm led dimmer
`timescale 1ns/1ns

module pwm_dimmer (
  input  logic                clk,
  input  logic                rst_i,
  input  ring_pkg::led_mask_t mask_i,
  input  ring_pkg::duty_t     duty_i,
  output ring_pkg::led_mask_t led_o
);
  import ring_pkg::*;

  duty_t frame_cnt;  // wraps every 256 cycles
  logic  pwm_en;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      frame_cnt <= '0;
    end else begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // on for duty_i cycles per frame
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pwm_en <= 1'b0;
    end else begin
      pwm_en <= (frame_cnt < duty_i);
    end
  end

  // all leds switch on the same edge
  always_ff @(posedge clk) begin
    if (rst_i) begin
      led_o <= '0;
    end else begin
      led_o <= mask_i & {RING_LEDS{pwm_en}};
    end
  end

endmodule

//--- design/ring_top.sv
// led ring controller top level
`timescale 1ns/1ns

module ring_top (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                enc_a_i,
  input  logic                enc_b_i,
  input  logic                button_i,
  input  ring_pkg::level_t    level_i,
  output ring_pkg::led_mask_t led_o,
  output ring_pkg::status_t   status_o
);
  import ring_pkg::*;

  logic      step_up;
  logic      step_dn;
  logic      press;
  led_mask_t mask;   // after inversion, before dimming
  duty_t     duty;

  quad_decoder quad_decoder_inst (
    .clk       (clk),
    .rst_i     (rst_i),
    .enc_a_i   (enc_a_i),
    .enc_b_i   (enc_b_i),
    .step_up_o (step_up),
    .step_dn_o (step_dn)
  );

  button_debounce button_debounce_inst (
    .clk      (clk),
    .rst_i    (rst_i),
    .button_i (button_i),
    .press_o  (press)
  );

  ring_controller ring_controller_inst (
    .clk       (clk),
    .rst_i     (rst_i),
    .step_up_i (step_up),
    .step_dn_i (step_dn),
    .press_i   (press),
    .level_i   (level_i),
    .mask_o    (mask),
    .duty_o    (duty),
    .status_o  (status_o)
  );

  pwm_dimmer pwm_dimmer_inst (
    .clk    (clk),
    .rst_i  (rst_i),
    .mask_i (mask),
    .duty_i (duty),
    .led_o  (led_o)
  );

endmodule

//--- dv/ring_tb.sv
// led ring directed testbench
`timescale 1ns/1ns

module ring_tb;
  import ring_pkg::*;
  import input_pkg::*;

  logic      clk;
  logic      rst_i;
  logic      enc_a_i;
  logic      enc_b_i;
  logic      button_i;
  level_t    level_i;
  led_mask_t led_o;
  status_t   status_o;

  int     model_pos;     // expected lit index
  logic   model_inv;     // expected inversion flag
  int     errors;
  int     tests_passed;
  int     tests_failed;
  integer seed;

  ring_top ring_top_inst (
    .clk      (clk),
    .rst_i    (rst_i),
    .enc_a_i  (enc_a_i),
    .enc_b_i  (enc_b_i),
    .button_i (button_i),
    .level_i  (level_i),
    .led_o    (led_o),
    .status_o (status_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic status_t model_status();
    return {model_inv, 4'(model_pos)};
  endfunction

  function automatic int duty_for_level(input int lvl);
    case (lvl)
      0:       return 1;
      1:       return 2;
      2:       return 8;
      default: return 32;
    endcase
  endfunction

  // poll status_o until it settles on the model value
  task automatic wait_status(input status_t exp);
    int n;
    n = 0;
    @(negedge clk);
    while (status_o !== exp && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (status_o !== exp) begin
      $display("timed out after %0d cycles waiting for status_o to read %h, it reads %h",
               n, exp, status_o);
      errors++;
    end
  endtask

  // one quadrature phase, 4 cycles
  task automatic drive_enc(input logic a, input logic b);
    @(posedge clk);
    enc_a_i <= a;
    enc_b_i <= b;
    repeat (3) @(posedge clk);
  endtask

  task automatic enc_step_up();
    drive_enc(1'b1, 1'b0);  // a rises with b low
    drive_enc(1'b1, 1'b1);
    drive_enc(1'b0, 1'b1);
    drive_enc(1'b0, 1'b0);
    model_pos = (model_pos + 1) % RING_LEDS;
  endtask

  task automatic enc_step_dn();
    drive_enc(1'b0, 1'b1);
    drive_enc(1'b1, 1'b1);  // a rises with b high
    drive_enc(1'b1, 1'b0);
    drive_enc(1'b0, 1'b0);
    model_pos = (model_pos + RING_LEDS - 1) % RING_LEDS;
  endtask

  task automatic press_button();
    @(posedge clk);
    button_i <= 1'b1;
    repeat (24) @(posedge clk);
    button_i <= 1'b0;
    repeat (24) @(posedge clk);
    model_inv = ~model_inv;
  endtask

  // runs all shorter than the debounce window
  task automatic bounce_button();
    int runs[6];
    runs = '{5, 3, 10, 7, DEBOUNCE_CYCLES - 4, 9};
    foreach (runs[i]) begin
      @(posedge clk);
      button_i <= ~button_i;
      repeat (runs[i] - 1) @(posedge clk);
    end
    @(posedge clk);
    button_i <= 1'b0;
  endtask

  // number of cycles in 256 where one led_o bit is high
  task automatic count_on(input int bit_idx, output int cnt, output logic others);
    cnt = 0;
    others = 1'b0;
    repeat (256) begin
      @(negedge clk);
      if (led_o[bit_idx]) cnt++;
      if ((led_o & ~(led_mask_t'(1) << bit_idx)) != '0) others = 1'b1;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("%s: ok", name);
      tests_passed++;
    end else begin
      $display("%s: %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  task automatic check_reset_state();
    int   e0;
    int   cnt;
    logic others;
    e0 = errors;
    @(negedge clk);
    if (status_o !== '0) begin
      $display("FAIL t=%0t status_o after reset is %h, expected 0", $time, status_o);
      errors++;
    end
    count_on(0, cnt, others);
    if (cnt != 1 || others) begin
      $display("FAIL t=%0t led 0 on %0d cycles, other leds lit %b", $time, cnt, others);
      errors++;
    end
    finish_test("reset state", e0);
  endtask

  task automatic rotate_with_wrap();
    int e0;
    e0 = errors;
    repeat (RING_LEDS) begin
      enc_step_up();
      wait_status(model_status());
    end
    if (status_o[3:0] !== 4'd0) begin
      $display("FAIL t=%0t index %0d after full turn, expected 0", $time, status_o[3:0]);
      errors++;
    end
    enc_step_dn();  // 0 down to 11
    wait_status(model_status());
    finish_test("rotation with wrap", e0);
  endtask

  task automatic toggle_inversion();
    int        e0;
    int        n;
    led_mask_t exp;
    e0 = errors;
    press_button();
    wait_status(model_status());
    exp = ~(led_mask_t'(1) << model_pos);
    n = 0;
    @(negedge clk);
    while (led_o == '0 && n < 300) begin
      @(negedge clk);
      n++;
    end
    if (led_o == '0) begin
      $display("timed out waiting for the pwm enable to light led_o");
      errors++;
    end else if (led_o !== exp) begin
      $display("FAIL t=%0t led_o %h, expected %h", $time, led_o, exp);
      errors++;
    end
    press_button();
    wait_status(model_status());
    finish_test("inversion", e0);
  endtask

  task automatic reject_bounce();
    int e0;
    e0 = errors;
    bounce_button();
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      if (status_o !== model_status()) begin
        $display("FAIL t=%0t bounce changed status_o to %h", $time, status_o);
        errors++;
        break;
      end
    end
    press_button();
    wait_status(model_status());
    finish_test("debounce rejection", e0);
  endtask

  task automatic sweep_brightness();
    int   e0;
    int   cnt;
    int   lit;
    logic others;
    e0 = errors;
    lit = model_inv ? (model_pos + 1) % RING_LEDS : model_pos;  // a bit that is on
    for (int lvl = 0; lvl < 4; lvl++) begin
      @(posedge clk);
      level_i <= level_t'(lvl);
      repeat (4) @(posedge clk);  // duty and compare settle
      count_on(lit, cnt, others);
      if (cnt != duty_for_level(lvl)) begin
        $display("FAIL t=%0t level %0d gave %0d on cycles, expected %0d",
                 $time, lvl, cnt, duty_for_level(lvl));
        errors++;
      end
      // other leds are lit only when the mask is inverted
      if (others !== model_inv) begin
        $display("FAIL t=%0t level %0d other leds lit %b, expected %b",
                 $time, lvl, others, model_inv);
        errors++;
      end
    end
    finish_test("brightness", e0);
  endtask

  task automatic run_random_sequence();
    int e0;
    int act;
    e0 = errors;
    repeat (30) begin
      act = ($random(seed) & 32'h7fff_ffff) % 3;
      case (act)
        0:       enc_step_up();
        1:       enc_step_dn();
        default: press_button();
      endcase
      wait_status(model_status());
    end
    finish_test("random sequence", e0);
  endtask

  initial begin
    rst_i        = 1'b1;
    enc_a_i      = 1'b0;
    enc_b_i      = 1'b0;
    button_i     = 1'b0;
    level_i      = '0;
    model_pos    = 0;
    model_inv    = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    seed         = 32'h9c924ae2;
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;

    check_reset_state();
    rotate_with_wrap();
    toggle_inversion();
    reject_bounce();
    sweep_brightness();
    run_random_sequence();

    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- list.f
design/ring_pkg.sv
design/input_pkg.sv
design/quad_decoder.sv
design/button_debounce.sv
design/ring_controller.sv
design/pwm_dimmer.sv
design/ring_top.sv
dv/ring_tb.sv
